// ==== logic/host_pkg.sv ====
// Host interface package with download and SD buffer widths and download file-type codes
package host_pkg;

    ////////////////////////////////////////////////////////////////////
    // Download stream
    ////////////////////////////////////////////////////////////////////

    localparam int ioctl_addr_w = 25;
    localparam int ioctl_data_w = 16;

    // Download index sent by the host with each file
    typedef enum logic [7:0] {
        ft_rom_gb   = 8'h01,
        ft_border   = 8'h02,
        ft_palette  = 8'h03,
        ft_bios     = 8'h40,
        ft_rom_gbc  = 8'h41,
        ft_rom_alt  = 8'h80,
        ft_cheat    = 8'hFF
    } file_type_t;

    ////////////////////////////////////////////////////////////////////
    // SD block buffer
    ////////////////////////////////////////////////////////////////////

    localparam int lba_w       = 32;
    // 256 words of 16 bits per 512-byte block
    localparam int buff_addr_w = 8;
    localparam int buff_data_w = 16;

endpackage

// ==== logic/backup_pkg.sv ====
// Backup RAM package with block geometry, clock-word layout and sequencer states
package backup_pkg;

    ////////////////////////////////////////////////////////////////////
    // Block geometry
    ////////////////////////////////////////////////////////////////////

    // Low part of the SD block address, compared against the RAM mask
    localparam int block_idx_w = 8;

    // Block number above the word index, zero-extended
    localparam int bk_addr_w = 17;

    ////////////////////////////////////////////////////////////////////
    // Real-time clock save block
    ////////////////////////////////////////////////////////////////////

    localparam int rtc_stamp_w = 32;
    localparam int rtc_saved_w = 48;
    localparam int rtc_word_w  = 16;

    // Words 5 and up of the clock block are unused
    localparam logic [rtc_word_w-1:0] rtc_fill_word = 16'hFFFF;

    ////////////////////////////////////////////////////////////////////
    // Block sequencer
    ////////////////////////////////////////////////////////////////////

    typedef enum logic {
        bk_idle = 1'b0,
        bk_busy = 1'b1
    } bk_state_t;

endpackage

// ==== logic/download_monitor.sv ====
// Download monitor that flags cartridge downloads, their end and a writable save image
module download_monitor
    import host_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       ioctl_download,
    input  file_type_t file_type,
    input  logic       img_mounted,
    input  logic       img_readonly,
    output logic       cart_download,
    output logic       download_done,
    output logic       bk_ena
);

    logic cart_download_q;
    logic is_rom;

    // Only the ROM indexes count as a cartridge download
    always_comb begin
        case (file_type)
            ft_rom_gb,
            ft_rom_gbc,
            ft_rom_alt: is_rom = 1'b1;
            default:    is_rom = 1'b0;
        endcase
    end

    assign cart_download = ioctl_download && is_rom;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cart_download_q <= 1'b0;
            download_done   <= 1'b0;
            bk_ena          <= 1'b0;
        end else begin
            cart_download_q <= cart_download;

            // One-cycle pulse once the ROM stream has ended
            download_done <= cart_download_q && !cart_download;

            // A new ROM forgets the previous save image
            if (!cart_download_q && cart_download) begin
                bk_ena <= 1'b0;
            end

            // Host mounts the save file while the ROM is still streaming
            if (cart_download && img_mounted && !img_readonly) begin
                bk_ena <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/save_tracker.sv ====
// Save tracker that remembers unsaved cartridge RAM writes and a pending fresh load
module save_tracker (
    input  logic clk_sys,
    input  logic reset,
    input  logic bk_ena,
    input  logic cart_has_save,
    input  logic cram_wr,
    input  logic osd_open,
    input  logic download_done,
    input  logic bk_busy,
    output logic sav_pending,
    output logic new_load
);

    logic sav_supported;

    // Cartridge has battery RAM and a writable image is mounted
    assign sav_supported = cart_has_save && bk_ena;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sav_pending <= 1'b0;
            new_load    <= 1'b0;
        end else begin
            // Game writes while the menu is closed mark the RAM dirty
            if (cram_wr && !osd_open && sav_supported) begin
                sav_pending <= 1'b1;
            end else if (bk_busy) begin
                sav_pending <= 1'b0;
            end

            // Fresh ROM with a save file wants its backup read in
            if (download_done && sav_supported) begin
                new_load <= 1'b1;
            end else if (bk_busy) begin
                new_load <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/backup_sequencer.sv ====
// Block sequencer that walks the SD block address for a whole backup load or save
module backup_sequencer
    import host_pkg::*;
    import backup_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   bk_ena,
    input  logic                   new_load,
    input  logic                   sav_pending,
    input  logic                   load_cmd,
    input  logic                   save_cmd,
    input  logic                   autosave,
    input  logic                   osd_open,
    input  logic                   download_done,
    input  logic                   img_present,
    input  logic                   rtc_inuse,
    input  logic [block_idx_w-1:0] ram_mask,
    input  logic                   sd_ack,
    output logic [lba_w-1:0]       sd_lba,
    output logic                   sd_rd,
    output logic                   sd_wr,
    output logic                   bk_busy,
    output logic                   bk_loading
);

    bk_state_t state;

    logic load_req;
    logic save_req;
    logic load_q;
    logic save_q;
    logic ack_q;
    logic load_edge;
    logic save_edge;
    logic ack_rise;
    logic ack_fall;
    logic last_block;
    logic [block_idx_w-1:0] block_idx;

    // Menu commands, plus autosave when the menu opens on dirty RAM
    assign load_req = load_cmd || new_load;
    assign save_req = save_cmd || (sav_pending && osd_open && autosave);

    assign load_edge = load_req && !load_q;
    assign save_edge = save_req && !save_q;
    assign ack_rise  = sd_ack && !ack_q;
    assign ack_fall  = !sd_ack && ack_q;

    assign block_idx = sd_lba[block_idx_w-1:0];

    // The clock block sits one past the last RAM block
    assign last_block = rtc_inuse ? (block_idx > ram_mask) : (block_idx >= ram_mask);

    assign bk_busy = (state == backup_pkg::bk_busy);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= bk_idle;
            sd_lba     <= '0;
            sd_rd      <= 1'b0;
            sd_wr      <= 1'b0;
            bk_loading <= 1'b0;
            load_q     <= 1'b0;
            save_q     <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            load_q <= load_req;
            save_q <= save_req;
            ack_q  <= sd_ack;

            // Host has taken the request
            if (ack_rise) begin
                sd_rd <= 1'b0;
                sd_wr <= 1'b0;
            end

            case (state)
                bk_idle: begin
                    if (bk_ena && download_done && img_present) begin
                        // End of a ROM download reads the save image in
                        state      <= backup_pkg::bk_busy;
                        bk_loading <= 1'b1;
                        sd_lba     <= '0;
                        sd_rd      <= 1'b1;
                        sd_wr      <= 1'b0;
                    end else if (bk_ena && (load_edge || save_edge)) begin
                        state      <= backup_pkg::bk_busy;
                        bk_loading <= load_edge;
                        sd_lba     <= '0;
                        sd_rd      <= load_edge;
                        sd_wr      <= !load_edge;
                    end
                end
                default: begin
                    // Block finished when the host drops its acknowledge
                    if (ack_fall) begin
                        if (last_block) begin
                            state      <= bk_idle;
                            bk_loading <= 1'b0;
                        end else begin
                            sd_lba <= sd_lba + 1'b1;
                            sd_rd  <= bk_loading;
                            sd_wr  <= !bk_loading;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== logic/sector_router.sv ====
// Sector router between the SD buffer, cartridge backup RAM and the clock save words
module sector_router
    import host_pkg::*;
    import backup_pkg::*;
(
    input  logic [block_idx_w-1:0] block_idx,
    input  logic [block_idx_w-1:0] ram_mask,
    input  logic [buff_addr_w-1:0] sd_buff_addr,
    input  logic [buff_data_w-1:0] sd_buff_dout,
    input  logic                   sd_buff_wr,
    input  logic                   sd_ack,
    input  logic [buff_data_w-1:0] bk_q,
    input  logic [rtc_stamp_w-1:0] rtc_timestamp,
    input  logic [rtc_saved_w-1:0] rtc_savedtime,
    output logic [bk_addr_w-1:0]   bk_addr,
    output logic [buff_data_w-1:0] bk_data,
    output logic                   bk_wr,
    output logic                   bk_rtc_wr,
    output logic [buff_data_w-1:0] sd_buff_din
);

    logic in_ram;
    logic host_wr;

    // Blocks up to the mask hold save RAM, the next one holds the clock
    assign in_ram  = (block_idx <= ram_mask);
    assign host_wr = sd_buff_wr && sd_ack;

    assign bk_addr   = bk_addr_w'({block_idx, sd_buff_addr});
    assign bk_data   = sd_buff_dout;
    assign bk_wr     = host_wr && in_ram;
    assign bk_rtc_wr = host_wr && !in_ram;

    // Readback toward the host
    always_comb begin
        if (in_ram) begin
            sd_buff_din = bk_q;
        end else begin
            case (sd_buff_addr)
                8'd0:    sd_buff_din = rtc_timestamp[15:0];
                8'd1:    sd_buff_din = rtc_timestamp[31:16];
                8'd2:    sd_buff_din = rtc_savedtime[15:0];
                8'd3:    sd_buff_din = rtc_savedtime[31:16];
                8'd4:    sd_buff_din = rtc_savedtime[47:32];
                default: sd_buff_din = rtc_fill_word;
            endcase
        end
    end

endmodule

// ==== logic/backup_top.sv ====
// Backup RAM top level joining download tracking, save tracking, block sequencing and routing
module backup_top
    import host_pkg::*;
    import backup_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   ioctl_download,
    input  file_type_t             file_type,
    input  logic                   img_mounted,
    input  logic                   img_readonly,
    input  logic                   img_present,
    input  logic                   cart_has_save,
    input  logic                   cram_wr,
    input  logic                   osd_open,
    input  logic                   load_cmd,
    input  logic                   save_cmd,
    input  logic                   autosave,
    input  logic                   rtc_inuse,
    input  logic [block_idx_w-1:0] ram_mask,
    input  logic                   sd_ack,
    input  logic [buff_addr_w-1:0] sd_buff_addr,
    input  logic [buff_data_w-1:0] sd_buff_dout,
    input  logic                   sd_buff_wr,
    input  logic [buff_data_w-1:0] bk_q,
    input  logic [rtc_stamp_w-1:0] rtc_timestamp,
    input  logic [rtc_saved_w-1:0] rtc_savedtime,
    output logic [lba_w-1:0]       sd_lba,
    output logic                   sd_rd,
    output logic                   sd_wr,
    output logic [buff_data_w-1:0] sd_buff_din,
    output logic [bk_addr_w-1:0]   bk_addr,
    output logic [buff_data_w-1:0] bk_data,
    output logic                   bk_wr,
    output logic                   bk_rtc_wr,
    output logic                   led_save
);

    logic download_done;
    logic bk_ena;
    logic sav_pending;
    logic new_load;
    logic bk_busy;

    ////////////////////////////////////////////////////////////////////
    // Download and dirty tracking
    ////////////////////////////////////////////////////////////////////

    download_monitor download_monitor_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .file_type      (file_type),
        .img_mounted    (img_mounted),
        .img_readonly   (img_readonly),
        .cart_download  (),
        .download_done  (download_done),
        .bk_ena         (bk_ena)
    );

    save_tracker save_tracker_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .bk_ena        (bk_ena),
        .cart_has_save (cart_has_save),
        .cram_wr       (cram_wr),
        .osd_open      (osd_open),
        .download_done (download_done),
        .bk_busy       (bk_busy),
        .sav_pending   (sav_pending),
        .new_load      (new_load)
    );

    ////////////////////////////////////////////////////////////////////
    // Block transfers
    ////////////////////////////////////////////////////////////////////

    backup_sequencer backup_sequencer_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .bk_ena        (bk_ena),
        .new_load      (new_load),
        .sav_pending   (sav_pending),
        .load_cmd      (load_cmd),
        .save_cmd      (save_cmd),
        .autosave      (autosave),
        .osd_open      (osd_open),
        .download_done (download_done),
        .img_present   (img_present),
        .rtc_inuse     (rtc_inuse),
        .ram_mask      (ram_mask),
        .sd_ack        (sd_ack),
        .sd_lba        (sd_lba),
        .sd_rd         (sd_rd),
        .sd_wr         (sd_wr),
        .bk_busy       (bk_busy),
        .bk_loading    ()
    );

    // Low byte of the block address selects the RAM block
    sector_router sector_router_i (
        .block_idx     (sd_lba[block_idx_w-1:0]),
        .ram_mask      (ram_mask),
        .sd_buff_addr  (sd_buff_addr),
        .sd_buff_dout  (sd_buff_dout),
        .sd_buff_wr    (sd_buff_wr),
        .sd_ack        (sd_ack),
        .bk_q          (bk_q),
        .rtc_timestamp (rtc_timestamp),
        .rtc_savedtime (rtc_savedtime),
        .bk_addr       (bk_addr),
        .bk_data       (bk_data),
        .bk_wr         (bk_wr),
        .bk_rtc_wr     (bk_rtc_wr),
        .sd_buff_din   (sd_buff_din)
    );

    // Lit while downloading or while RAM holds unsaved data
    assign led_save = sav_pending || ioctl_download;

endmodule

// ==== verification/backup_tb.sv ====
// Backup RAM testbench with an SD host model, download and menu stimulus and assertion checks
module backup_tb
    import host_pkg::*;
    import backup_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // Generous bound over the worst-case length of the whole scenario list
    localparam int max_cycles = 4000;

    logic                   clk_sys = 1'b0;
    logic                   reset;
    logic                   ioctl_download;
    file_type_t             file_type;
    logic                   img_mounted;
    logic                   img_readonly;
    logic                   img_present;
    logic                   cart_has_save;
    logic                   cram_wr;
    logic                   osd_open;
    logic                   load_cmd;
    logic                   save_cmd;
    logic                   autosave;
    logic                   rtc_inuse;
    logic [block_idx_w-1:0] ram_mask;
    logic                   sd_ack;
    logic [buff_addr_w-1:0] sd_buff_addr;
    logic [buff_data_w-1:0] sd_buff_dout;
    logic                   sd_buff_wr;
    logic [buff_data_w-1:0] bk_q;
    logic [rtc_stamp_w-1:0] rtc_timestamp;
    logic [rtc_saved_w-1:0] rtc_savedtime;
    logic [lba_w-1:0]       sd_lba;
    logic                   sd_rd;
    logic                   sd_wr;
    logic [buff_data_w-1:0] sd_buff_din;
    logic [bk_addr_w-1:0]   bk_addr;
    logic [buff_data_w-1:0] bk_data;
    logic                   bk_wr;
    logic                   bk_rtc_wr;
    logic                   led_save;

    // Expected run state kept by the stimulus and the host model
    logic                   quiet;
    int                     run_kind;
    logic [lba_w-1:0]       exp_lba;
    logic [block_idx_w-1:0] cur_block;
    int                     blocks_served;
    logic [1:0]             exp_strobes;
    logic [buff_data_w-1:0] exp_din;
    int                     value_errors = 0;
    int                     other_errors = 0;
    int                     cycles = 0;

    always #2 clk_sys = ~clk_sys;

    backup_top dut_i (.*);

    //////////////////////////////////////////////////////////////////////
    // Expected values and run bookkeeping
    //////////////////////////////////////////////////////////////////////

    // Clock block words are stamp low, stamp high, then saved time low to high
    function automatic logic [buff_data_w-1:0] rtc_word(input logic [buff_addr_w-1:0] word);
        logic [buff_data_w-1:0] value;
        case (word)
            8'd0:    value = rtc_timestamp[15:0];
            8'd1:    value = rtc_timestamp[31:16];
            8'd2:    value = rtc_savedtime[15:0];
            8'd3:    value = rtc_savedtime[31:16];
            8'd4:    value = rtc_savedtime[47:32];
            default: value = 16'hFFFF;
        endcase
        return value;
    endfunction

    // Host writes land in RAM up to the mask and in the clock words above it
    assign exp_strobes = !(sd_ack && sd_buff_wr) ? 2'b00
                       : (cur_block <= ram_mask) ? 2'b10 : 2'b01;
    assign exp_din     = (cur_block <= ram_mask) ? bk_q : rtc_word(sd_buff_addr);

    task automatic print_summary();
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    endtask

    task automatic prepare_run(input int kind);
        run_kind = kind;
        exp_lba = '0;
        blocks_served = 0;
    endtask

    task automatic wait_start();
        int guard;
        guard = 0;
        while (!dut_i.bk_busy && guard < 8) begin
            @(negedge clk_sys);
            guard++;
        end
        assert (dut_i.bk_busy) else begin
            other_errors++;
            $display("No block transfer started after the request");
        end
    endtask

    task automatic wait_end(input int blocks);
        while (dut_i.bk_busy) begin
            @(negedge clk_sys);
        end
        assert (blocks_served == blocks) else begin
            value_errors++;
            $display("error block count: expected 0x%0h got 0x%0h", blocks, blocks_served);
        end
        run_kind = 0;
    endtask

    task automatic download_rom(input logic readonly);
        file_type = ft_rom_gbc;
        ioctl_download = 1'b1;
        repeat (3) @(negedge clk_sys);
        img_mounted = 1'b1;
        img_readonly = readonly;
        @(negedge clk_sys);
        img_mounted = 1'b0;
        repeat (3) @(negedge clk_sys);
        ioctl_download = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // SD host model
    //////////////////////////////////////////////////////////////////////

    task automatic serve_block();
        int lag;
        logic [buff_addr_w-1:0] word;
        lag = $urandom_range(6, 1);
        assert (sd_lba == exp_lba) else begin
            value_errors++;
            $display("error sd_lba: expected 0x%0h got 0x%0h", exp_lba, sd_lba);
        end
        assert (sd_rd == (run_kind == 1)) else begin
            value_errors++;
            $display("error sd_rd: expected 0x%0h got 0x%0h", run_kind == 1, sd_rd);
        end
        cur_block = exp_lba[block_idx_w-1:0];
        repeat (lag - 1) @(negedge clk_sys);
        sd_ack = 1'b1;
        // Words 0 to 4 then one word past the clock fields
        for (int i = 0; i < 6; i++) begin
            word = (i < 5) ? 8'(i) : 8'(5 + $urandom_range(250));
            sd_buff_addr = word;
            sd_buff_wr = (i < 4);
            sd_buff_dout = 16'($urandom);
            bk_q = 16'($urandom);
            @(negedge clk_sys);
        end
        sd_buff_wr = 1'b0;
        sd_ack = 1'b0;
        exp_lba = exp_lba + 1;
        blocks_served++;
    endtask

    initial begin : sd_host
        void'($urandom(40));
        sd_ack = 1'b0;
        sd_buff_addr = '0;
        sd_buff_dout = '0;
        sd_buff_wr = 1'b0;
        bk_q = '0;
        forever begin
            @(negedge clk_sys);
            if (sd_rd || sd_wr) begin
                serve_block();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
        else begin
            other_errors++;
            $display("Read and write requests were high at the same time");
        end

    assert property (@(posedge clk_sys) disable iff (reset)
        quiet |-> !(sd_rd || sd_wr || led_save))
        else begin
            value_errors++;
            $display("error {sd_rd,sd_wr,led_save}: expected 0x0 got 0x%0h",
                $sampled({sd_rd, sd_wr, led_save}));
        end

    assert property (@(posedge clk_sys) disable iff (reset) (run_kind == 1) |-> !sd_wr)
        else begin
            value_errors++;
            $display("error sd_wr: expected 0x0 got 0x%0h", $sampled(sd_wr));
        end

    assert property (@(posedge clk_sys) disable iff (reset) (run_kind == 2) |-> !sd_rd)
        else begin
            value_errors++;
            $display("error sd_rd: expected 0x0 got 0x%0h", $sampled(sd_rd));
        end

    // Strobes follow the block type only while the host writes
    assert property (@(posedge clk_sys) disable iff (reset)
        {bk_wr, bk_rtc_wr} == exp_strobes)
        else begin
            value_errors++;
            $display("error {bk_wr,bk_rtc_wr}: expected 0x%0h got 0x%0h",
                $sampled(exp_strobes), $sampled({bk_wr, bk_rtc_wr}));
        end

    assert property (@(posedge clk_sys) disable iff (reset)
        sd_ack |-> (sd_buff_din == exp_din))
        else begin
            value_errors++;
            $display("error sd_buff_din: expected 0x%0h got 0x%0h",
                $sampled(exp_din), $sampled(sd_buff_din));
        end

    assert property (@(posedge clk_sys) disable iff (reset)
        sd_ack |-> (bk_addr == {1'b0, cur_block, sd_buff_addr}))
        else begin
            value_errors++;
            $display("error bk_addr: expected 0x%0h got 0x%0h",
                $sampled({1'b0, cur_block, sd_buff_addr}), $sampled(bk_addr));
        end

    assert property (@(posedge clk_sys) disable iff (reset)
        sd_ack |-> (bk_data == sd_buff_dout))
        else begin
            value_errors++;
            $display("error bk_data: expected 0x%0h got 0x%0h",
                $sampled(sd_buff_dout), $sampled(bk_data));
        end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            print_summary();
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        ioctl_download = 1'b0;
        file_type = ft_bios;
        img_mounted = 1'b0;
        img_readonly = 1'b0;
        img_present = 1'b0;
        cart_has_save = 1'b1;
        cram_wr = 1'b0;
        osd_open = 1'b0;
        load_cmd = 1'b0;
        save_cmd = 1'b0;
        autosave = 1'b0;
        rtc_inuse = 1'b0;
        ram_mask = 8'd3;
        rtc_timestamp = 32'h6502_1a3c;
        rtc_savedtime = 48'h0017_0c2e_3b05;
        quiet = 1'b1;
        prepare_run(0);
        repeat (16) @(negedge clk_sys);
        reset = 1'b0;
        repeat (6) @(negedge clk_sys);
        quiet = 1'b0;

        // ROM with a writable save image loads blocks 0 to the mask
        prepare_run(1);
        img_present = 1'b1;
        download_rom(1'b0);
        wait_start();
        wait_end(int'(ram_mask) + 1);

        // Menu save with the clock block in use
        prepare_run(2);
        rtc_inuse = 1'b1;
        save_cmd = 1'b1;
        wait_start();
        save_cmd = 1'b0;
        wait_end(int'(ram_mask) + 2);

        // Dirty RAM then autosave when the menu opens
        cram_wr = 1'b1;
        @(negedge clk_sys);
        cram_wr = 1'b0;
        assert (led_save) else begin
            value_errors++;
            $display("error led_save: expected 0x1 got 0x%0h", led_save);
        end
        prepare_run(2);
        autosave = 1'b1;
        osd_open = 1'b1;
        wait_start();
        @(negedge clk_sys);
        assert (!led_save) else begin
            value_errors++;
            $display("error led_save: expected 0x0 got 0x%0h", led_save);
        end
        wait_end(int'(ram_mask) + 2);
        osd_open = 1'b0;
        autosave = 1'b0;

        // Read-only image leaves the backup path disabled
        download_rom(1'b1);
        quiet = 1'b1;
        repeat (4) @(negedge clk_sys);
        load_cmd = 1'b1;
        repeat (2) @(negedge clk_sys);
        load_cmd = 1'b0;
        repeat (10) @(negedge clk_sys);
        save_cmd = 1'b1;
        repeat (2) @(negedge clk_sys);
        save_cmd = 1'b0;
        repeat (10) @(negedge clk_sys);
        quiet = 1'b0;

        print_summary();
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/host_pkg.sv
logic/backup_pkg.sv
logic/download_monitor.sv
logic/save_tracker.sv
logic/backup_sequencer.sv
logic/sector_router.sv
logic/backup_top.sv
verification/backup_tb.sv

// ==== Makefile ====
SOURCES := $(filter-out +%,$(shell cat project.f))

.PHONY: run clean

obj_dir/Vbackup_tb: project.f $(SOURCES)
	verilator --binary --timing --assert --top-module backup_tb -f project.f

run: obj_dir/Vbackup_tb
	./obj_dir/Vbackup_tb | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
